// ==== div_pkg.sv ====
/* divide unit shared types */
`default_nettype none

package div_pkg;

    // data width; word mode takes the low half
    localparam int xlen = 64;

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_CALC = 2'd1,   // setup, shift and fix-up cycles
        LANE_DONE = 2'd2    // result held until drained
    } lane_state_e;

    // signed variants
    function automatic logic op_is_signed(input div_op_e op);
        return (op == OP_DIV) || (op == OP_REM);
    endfunction

    // remainder variants
    function automatic logic op_is_rem(input div_op_e op);
        return (op == OP_REM) || (op == OP_REMU);
    endfunction

endpackage

`default_nettype wire

// ==== div_dispatch.sv ====
/* round-robin request dispatcher */
`timescale 1ns/1ps
`default_nettype none

module div_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  div_pkg::div_op_e         in_op,
    input  logic                     in_word,
    input  logic [div_pkg::xlen-1:0] in_dividend,
    input  logic [div_pkg::xlen-1:0] in_divisor,
    output logic [NUM_LANES-1:0]     lane_req_valid,
    input  logic [NUM_LANES-1:0]     lane_req_ready,
    output div_pkg::div_op_e         lane_op,
    output logic                     lane_word,
    output logic [div_pkg::xlen-1:0] lane_dividend,
    output logic [div_pkg::xlen-1:0] lane_divisor
);

    localparam int lane_sel_w = $clog2(NUM_LANES);

    logic [lane_sel_w-1:0] ptr_q;   // lane that takes the next request
    logic                  xfer;

    // stall on a busy lane even if another one is idle, keeps order
    assign in_ready = lane_req_ready[ptr_q];
    assign xfer     = in_valid && in_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_req_valid[i] = in_valid && (ptr_q == lane_sel_w'(i));
        end
    end

    // operands go out on shared buses, only the valid is steered
    assign lane_op       = in_op;
    assign lane_word     = in_word;
    assign lane_dividend = in_dividend;
    assign lane_divisor  = in_divisor;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (xfer) begin
            if (ptr_q == lane_sel_w'(NUM_LANES - 1)) begin
                ptr_q <= '0;        // wrap
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== div_lane.sv ====
/* restoring divider lane */
`timescale 1ns/1ps
`default_nettype none

module div_lane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  div_pkg::div_op_e         op,
    input  logic                     word,
    input  logic [div_pkg::xlen-1:0] dividend,
    input  logic [div_pkg::xlen-1:0] divisor,
    output logic                     res_valid,
    input  logic                     res_ready,
    output logic [div_pkg::xlen-1:0] res_data
);

    import div_pkg::*;

    localparam int wlen = xlen / 2;

    lane_state_e       state_q;
    logic              setup_q;     // first cycle after accept
    logic              fix_q;       // shifts done, fix-up next
    logic [2*xlen-1:0] rem_q;       // partial remainder : dividend
    logic [xlen-1:0]   dvs_q;
    logic [xlen-1:0]   quo_q;
    logic [5:0]        cnt_q;
    logic              word_q;
    logic              is_rem_q;
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic              zero_q;
    logic              ovf_q;
    logic [xlen-1:0]   res_q;

    logic              accept;
    logic              sgn_op;
    logic              dvd_neg;
    logic              dvs_neg;
    logic [xlen-1:0]   dvd_abs;
    logic [xlen-1:0]   dvs_abs;
    logic [wlen-1:0]   dvd_abs_w;
    logic [wlen-1:0]   dvs_abs_w;
    logic              dvs_zero;
    logic              dvd_min;
    logic              dvs_m1;

    logic              shift_en;
    logic              finish;
    logic [xlen:0]     top;
    logic [xlen:0]     diff;
    logic              q_bit;

    logic [xlen-1:0]   ovf_quo;
    logic [xlen-1:0]   rem_mag;
    logic [xlen-1:0]   quo_fix;
    logic [xlen-1:0]   rem_fix;
    logic [xlen-1:0]   pick;
    logic [xlen-1:0]   fix_res;

    assign req_ready = (state_q == LANE_IDLE);
    assign res_valid = (state_q == LANE_DONE);
    assign res_data  = res_q;

    // operand conditioning at accept
    assign accept    = req_valid && req_ready;
    assign sgn_op    = op_is_signed(op);
    assign dvd_neg   = sgn_op && (word ? dividend[wlen-1] : dividend[xlen-1]);
    assign dvs_neg   = sgn_op && (word ? divisor[wlen-1] : divisor[xlen-1]);
    assign dvd_abs   = dvd_neg ? -dividend : dividend;
    assign dvs_abs   = dvs_neg ? -divisor : divisor;
    assign dvd_abs_w = dvd_neg ? -dividend[wlen-1:0] : dividend[wlen-1:0];
    assign dvs_abs_w = dvs_neg ? -divisor[wlen-1:0] : divisor[wlen-1:0];
    assign dvs_zero  = word ? (divisor[wlen-1:0] == '0) : (divisor == '0);
    assign dvd_min   = word ? (dividend[wlen-1:0] == {1'b1, {(wlen-1){1'b0}}})
                            : (dividend == {1'b1, {(xlen-1){1'b0}}});
    assign dvs_m1    = word ? (&divisor[wlen-1:0]) : (&divisor);

    // one compare-and-subtract per cycle
    assign shift_en = (state_q == LANE_CALC) && !setup_q && !fix_q;
    assign finish   = (state_q == LANE_CALC) && (fix_q || (setup_q && zero_q));
    assign top      = rem_q[2*xlen-1:xlen-1];
    assign diff     = top - {1'b0, dvs_q};
    assign q_bit    = !diff[xlen];      // no borrow

    // zero divisor keeps the dividend magnitude in the low half
    // overflow returns the most negative value and a zero remainder
    assign ovf_quo = word_q ? {{wlen{1'b0}}, 1'b1, {(wlen-1){1'b0}}}
                            : {1'b1, {(xlen-1){1'b0}}};
    assign rem_mag = !zero_q ? rem_q[2*xlen-1:xlen]
                   : word_q  ? {{wlen{1'b0}}, rem_q[xlen-1:wlen]}
                   : rem_q[xlen-1:0];
    assign quo_fix = zero_q    ? '1
                   : ovf_q     ? ovf_quo
                   : neg_quo_q ? -quo_q
                   : quo_q;
    assign rem_fix = ovf_q ? '0 : (neg_rem_q ? -rem_mag : rem_mag);
    assign pick    = is_rem_q ? rem_fix : quo_fix;
    assign fix_res = word_q ? {{wlen{pick[wlen-1]}}, pick[wlen-1:0]} : pick;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= LANE_IDLE;
            setup_q <= 1'b0;
            fix_q   <= 1'b0;
        end else begin
            case (state_q)
                LANE_IDLE: begin
                    if (accept) begin
                        state_q <= LANE_CALC;
                        setup_q <= 1'b1;
                    end
                end
                LANE_CALC: begin
                    if (finish) begin
                        state_q <= LANE_DONE;
                        setup_q <= 1'b0;
                        fix_q   <= 1'b0;
                    end else if (setup_q) begin
                        setup_q <= 1'b0;
                    end else if (cnt_q == 6'd0) begin
                        fix_q <= 1'b1;      // last shift this cycle
                    end
                end
                LANE_DONE: begin
                    if (res_ready) begin
                        state_q <= LANE_IDLE;
                    end
                end
                default: state_q <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q    <= word;
            is_rem_q  <= op_is_rem(op);
            neg_quo_q <= dvd_neg ^ dvs_neg;
            neg_rem_q <= dvd_neg;           // remainder follows dividend
            zero_q    <= dvs_zero;
            ovf_q     <= sgn_op && dvd_min && dvs_m1;
            quo_q     <= '0;
            cnt_q     <= word ? 6'd31 : 6'd63;
            if (word) begin
                rem_q <= {{xlen{1'b0}}, dvd_abs_w, {wlen{1'b0}}};   // msb at bit 63
                dvs_q <= {{wlen{1'b0}}, dvs_abs_w};
            end else begin
                rem_q <= {{xlen{1'b0}}, dvd_abs};
                dvs_q <= dvs_abs;
            end
        end
        if (shift_en) begin
            if (q_bit) begin
                rem_q <= {diff[xlen-1:0], rem_q[xlen-2:0], 1'b0};
            end else begin
                rem_q <= {rem_q[2*xlen-2:0], 1'b0};
            end
            quo_q <= {quo_q[xlen-2:0], q_bit};
            cnt_q <= cnt_q - 6'd1;
        end
        if (finish) begin
            res_q <= fix_res;
        end
    end

endmodule

`default_nettype wire

// ==== div_collect.sv ====
/* in-order result collector */
`timescale 1ns/1ps
`default_nettype none

module div_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [NUM_LANES-1:0]                    lane_res_valid,
    output logic [NUM_LANES-1:0]                    lane_res_ready,
    input  logic [NUM_LANES-1:0][div_pkg::xlen-1:0] lane_res_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [div_pkg::xlen-1:0]                out_result
);

    localparam int lane_sel_w = $clog2(NUM_LANES);

    logic [lane_sel_w-1:0] ptr_q;   // lane holding the oldest result
    logic                  xfer;

    // only the lane under the pointer is visible
    assign out_valid  = lane_res_valid[ptr_q];
    assign out_result = lane_res_data[ptr_q];
    assign xfer       = out_valid && out_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_res_ready[i] = out_ready && (ptr_q == lane_sel_w'(i));
        end
    end

    // later lanes wait even when done, so order matches dispatch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (xfer) begin
            if (ptr_q == lane_sel_w'(NUM_LANES - 1)) begin
                ptr_q <= '0;        // wrap
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== div_unit_top.sv ====
/* multi-lane divide unit */
`timescale 1ns/1ps
`default_nettype none

module div_unit_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  div_pkg::div_op_e         in_op,
    input  logic                     in_word,
    input  logic [div_pkg::xlen-1:0] in_dividend,
    input  logic [div_pkg::xlen-1:0] in_divisor,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [div_pkg::xlen-1:0] out_result
);

    import div_pkg::*;

    logic [NUM_LANES-1:0]           lane_req_valid;
    logic [NUM_LANES-1:0]           lane_req_ready;
    div_op_e                        lane_op;        // shared request buses
    logic                           lane_word;
    logic [xlen-1:0]                lane_dividend;
    logic [xlen-1:0]                lane_divisor;
    logic [NUM_LANES-1:0]           lane_res_valid;
    logic [NUM_LANES-1:0]           lane_res_ready;
    logic [NUM_LANES-1:0][xlen-1:0] lane_res_data;

    div_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) dispatch_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_op          (in_op),
        .in_word        (in_word),
        .in_dividend    (in_dividend),
        .in_divisor     (in_divisor),
        .lane_req_valid (lane_req_valid),
        .lane_req_ready (lane_req_ready),
        .lane_op        (lane_op),
        .lane_word      (lane_word),
        .lane_dividend  (lane_dividend),
        .lane_divisor   (lane_divisor)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        div_lane lane_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_valid (lane_req_valid[i]),
            .req_ready (lane_req_ready[i]),
            .op        (lane_op),
            .word      (lane_word),
            .dividend  (lane_dividend),
            .divisor   (lane_divisor),
            .res_valid (lane_res_valid[i]),
            .res_ready (lane_res_ready[i]),
            .res_data  (lane_res_data[i])
        );
    end

    div_collect #(
        .NUM_LANES (NUM_LANES)
    ) collect_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_res_valid (lane_res_valid),
        .lane_res_ready (lane_res_ready),
        .lane_res_data  (lane_res_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_result     (out_result)
    );

endmodule

`default_nettype wire

// ==== div_unit_assertions.sv ====
/* divide unit handshake checks */
`timescale 1ns/1ps
`default_nettype none

module div_unit_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     in_ready,
    input logic [div_pkg::xlen-1:0] in_dividend,
    input logic [div_pkg::xlen-1:0] in_divisor,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [div_pkg::xlen-1:0] out_result
);

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_dividend) && $stable(in_divisor))
        else $error("request dropped or changed before transfer");

    res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before transfer");

    res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_result))
        else $error("out_result changed while stalled");

    // state is cleared by the reset edge itself
    res_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind div_unit_top div_unit_assertions assertions_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_dividend (in_dividend),
    .in_divisor  (in_divisor),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result)
);

`default_nettype wire

// ==== tb_div_unit.sv ====
/* divide unit testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

    import div_pkg::*;

    localparam int max_vec = 64;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    div_op_e         in_op;
    logic            in_word;
    logic [xlen-1:0] in_dividend;
    logic [xlen-1:0] in_divisor;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_result;

    int              v_grp [max_vec];
    logic [1:0]      v_op  [max_vec];
    logic            v_word[max_vec];
    logic [xlen-1:0] v_dvd [max_vec];
    logic [xlen-1:0] v_dvs [max_vec];
    logic [xlen-1:0] v_exp [max_vec];
    int              n_vec;

    logic [xlen-1:0] exp_q[$];      // expected results in request order
    logic [xlen-1:0] cur_exp;       // expected value of the request on the bus
    logic [xlen-1:0] exp_val;
    int              checks = 0;
    int              errors = 0;
    int              cycle_count = 0;
    int              cycle_limit = 0;
    logic            random_ready = 1'b0;
    logic [15:0]     lfsr = 16'd58;
    logic            b0;
    logic            b1;

    div_unit_top #(
        .NUM_LANES (4)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_op       (in_op),
        .in_word     (in_word),
        .in_dividend (in_dividend),
        .in_divisor  (in_divisor),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic report_mismatch(input string name, input logic [xlen-1:0] expected,
                                   input logic [xlen-1:0] actual);
        $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    endtask

    // ready low only when both bits are set, so high 3 cycles in 4
    always @(negedge clk) begin
        if (random_ready) begin
            lfsr = lfsr_next(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_next(lfsr);
            b1 = lfsr[0];
            out_ready = !(b0 && b1);
        end else begin
            out_ready = 1'b1;
        end
    end

    // pop before push since a result never leaves on its own request edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("error at %0t ns: a result came out with no request pending",
                             $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_val = exp_q.pop_front();
                    assert (out_result === exp_val)
                        else report_mismatch("out_result", exp_val, out_result);
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(cur_exp);
            end
        end
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        int    g;
        string line;
        logic [1:0]      op;
        logic            w;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] r;
        n_vec = 0;
        fd = $fopen("div_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_vec < max_vec) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h", g, op, w, a, b, r);
                if (n == 6) begin       // comment and blank lines fall out here
                    v_grp[n_vec]  = g;
                    v_op[n_vec]   = op;
                    v_word[n_vec] = w;
                    v_dvd[n_vec]  = a;
                    v_dvs[n_vec]  = b;
                    v_exp[n_vec]  = r;
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // hold the request until it is taken at a rising edge
    task automatic send_vector(input int idx);
        in_valid    = 1'b1;
        in_op       = div_op_e'(v_op[idx]);
        in_word     = v_word[idx];
        in_dividend = v_dvd[idx];
        in_divisor  = v_dvs[idx];
        cur_exp     = v_exp[idx];
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic run_group(input int grp, input string name, input logic noisy);
        int err0;
        int sent;
        err0 = errors;
        sent = 0;
        random_ready = noisy;
        for (int i = 0; i < n_vec; i++) begin
            if (grp == 5 || v_grp[i] == grp) begin   // burst replays every vector
                send_vector(i);
                sent++;
            end
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        random_ready = 1'b0;
        $display("test %0d %s: %0d vectors, %0d errors", grp, name, sent, errors - err0);
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles with %0d results still pending",
                 cycle_count, exp_q.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = OP_DIV;
        in_word     = 1'b0;
        in_dividend = '0;
        in_divisor  = '0;
        out_ready   = 1'b1;
        cur_exp     = '0;
        load_vectors();
        if (n_vec == 0) begin
            $display("stimulus file div_stim.txt is missing or holds no vectors");
            $display("TEST FAIL");
            $finish;
        end else begin
            cycle_limit = n_vec * 70 * 2;
            repeat (10) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            checks += 2;
            assert (out_valid === 1'b0) else report_mismatch("out_valid", '0, 64'(out_valid));
            assert (in_ready === 1'b1) else report_mismatch("in_ready", 64'(1), 64'(in_ready));
            $display("test 1 reset state: 2 checks, %0d errors", errors);
            run_group(2, "64-bit divide", 1'b0);
            run_group(3, "word mode", 1'b0);
            run_group(4, "special cases", 1'b0);
            run_group(5, "burst with back-pressure", 1'b1);
            repeat (4) @(negedge clk);
            checks++;
            assert (out_valid === 1'b0) else report_mismatch("out_valid", '0, 64'(out_valid));
            $display("done: %0d vectors, %0d checks, %0d errors", n_vec, checks, errors);
            if (errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== div_stim.txt ====
# grp op word dividend divisor expected, all hex
# op 0 div, 1 divu, 2 rem, 3 remu; grp 2 64-bit, 3 word mode, 4 special cases
2 1 0 0000000000000064 0000000000000007 000000000000000e
2 3 0 0000000000000064 0000000000000007 0000000000000002
2 0 0 ffffffffffffff9c 0000000000000007 fffffffffffffff2
2 2 0 ffffffffffffff9c 0000000000000007 fffffffffffffffe
2 0 0 0000000000000064 fffffffffffffff9 fffffffffffffff2
2 2 0 0000000000000064 fffffffffffffff9 0000000000000002
2 0 0 ffffffffffffff9c fffffffffffffff9 000000000000000e
2 2 0 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
2 1 0 ffffffffffffffff 0000000000000010 0fffffffffffffff
2 3 0 ffffffffffffffff 0000000000000010 000000000000000f
2 1 0 123456789abcdef0 0000000000001000 000123456789abcd
2 3 0 123456789abcdef0 0000000000001000 0000000000000ef0
2 1 0 8000000000000000 0000000000000002 4000000000000000
2 0 0 8000000000000000 0000000000000002 c000000000000000
2 3 0 0000000000000005 0000000000000009 0000000000000005
3 0 1 deadbeefffffff9c 1234567800000007 fffffffffffffff2
3 2 1 deadbeefffffff9c 1234567800000007 fffffffffffffffe
3 1 1 abcdef01ffffffff 5555555500000010 000000000fffffff
3 3 1 abcdef01ffffffff 5555555500000010 000000000000000f
3 1 1 0000000080000000 ffffffff00000001 ffffffff80000000
3 0 1 1111111100000064 22222222fffffff9 fffffffffffffff2
3 2 1 1111111100000064 22222222fffffff9 0000000000000002
3 1 1 7777777700000064 0000000100000007 000000000000000e
3 3 1 fffffffffffffff0 0000000000000007 0000000000000002
3 1 1 fffffffffffffff0 0000000000000007 0000000024924922
3 0 1 5a5a5a5a80000000 0000000000000002 ffffffffc0000000
4 1 0 0000000000000123 0000000000000000 ffffffffffffffff
4 3 0 0000000000000123 0000000000000000 0000000000000123
4 0 0 ffffffffffffff9c 0000000000000000 ffffffffffffffff
4 2 0 ffffffffffffff9c 0000000000000000 ffffffffffffff9c
4 0 1 cafebabeffffff9c 1234567800000000 ffffffffffffffff
4 2 1 cafebabeffffff9c 1234567800000000 ffffffffffffff9c
4 3 1 cafebabe80000001 ffffffff00000000 ffffffff80000001
4 0 0 8000000000000000 ffffffffffffffff 8000000000000000
4 2 0 8000000000000000 ffffffffffffffff 0000000000000000
4 0 1 0123456780000000 abcdef01ffffffff ffffffff80000000
4 2 1 0123456780000000 abcdef01ffffffff 0000000000000000
4 1 0 8000000000000000 ffffffffffffffff 0000000000000000

// ==== project.f ====
div_pkg.sv
div_dispatch.sv
div_lane.sv
div_collect.sv
div_unit_top.sv
div_unit_assertions.sv
tb_div_unit.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench

TOP    ?= tb_div_unit
LOG    ?= sim.log
OBJ    ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: run clean

run:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ) -f project.f
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
